//--- ara_cfg_pkg.sv
//////////////////////////////////////////////////
// Vector accelerator configuration
// Lane count, element width and register count
// FIFO depths and the basic element and index types
//////////////////////////////////////////////////

package ara_cfg_pkg;

  // Machine shape
  localparam int unsigned NrLanes   = 4;
  localparam int unsigned ElenWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  // Queue depths
  localparam int unsigned InsnFifoDepth = 4;
  localparam int unsigned ResFifoDepth  = 2;

  // One element per lane per vector register
  typedef logic [ElenWidth-1:0] elen_t;

  // Index types
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;
  typedef logic [$clog2(NrLanes)-1:0] lane_idx_t;

endpackage : ara_cfg_pkg

//--- ara_insn_pkg.sv
//////////////////////////////////////////////////
// Vector instruction encoding
// Opcode enum, instruction struct, response struct
// and the reduction decode shared by sequencer and lanes
//////////////////////////////////////////////////

package ara_insn_pkg;

  import ara_cfg_pkg::*;

  //////////////////////////////////////////////////
  // Operations
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    VMV_VX,     // Splat of a scalar
    VID_V,      // Element index
    VADD_VX,    // Vector plus scalar
    VADD_VV,    // Vector plus vector
    VXOR_VX,    // Vector xor scalar
    VREDSUM_VS  // Sum of all elements plus scalar
  } vop_e;

  //////////////////////////////////////////////////
  // Instruction and response
  //////////////////////////////////////////////////

  // 44 bits in total
  typedef struct packed {
    vop_e      op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elen_t     scalar;
  } vinsn_t;

  // Scalar returned to the core
  typedef struct packed {
    elen_t result;
  } vres_t;

  // Reductions produce a scalar and leave the VRF alone
  function automatic logic is_reduction(vop_e op);
    return op == VREDSUM_VS;
  endfunction

endpackage : ara_insn_pkg

//--- ara_top.sv
//////////////////////////////////////////////////
// Vector accelerator top level
// Dispatcher, instruction and result FIFOs,
// sequencer and the lane array
//////////////////////////////////////////////////

`timescale 1ns/10ps

module ara_top import ara_cfg_pkg::*, ara_insn_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  // Core instruction channel
  input  logic   insn_req_i,
  input  vinsn_t insn_i,
  output logic   insn_ack_o,
  // Core response channel
  output logic   resp_req_o,
  output vres_t  resp_o,
  input  logic   resp_ack_i
);

  // Instruction path
  vinsn_t              insn_push_data;
  vinsn_t              insn_pop_data;
  logic                insn_push_valid;
  logic                insn_push_ready;
  logic                insn_pop_valid;
  logic                insn_pop_ready;
  // Result path
  vres_t               res_push_data;
  vres_t               res_pop_data;
  logic                res_push_valid;
  logic                res_push_ready;
  logic                res_pop_valid;
  logic                res_pop_ready;
  // Lane array
  vinsn_t              lane_cmd;
  logic                lane_issue;
  elen_t [NrLanes-1:0] lane_elem;

  //////////////////////////////////////////////////
  // Dispatcher
  //////////////////////////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i          ),
    .rst_n_i          (rst_n_i        ),
    .insn_req_i       (insn_req_i     ),
    .insn_i           (insn_i         ),
    .insn_ack_o       (insn_ack_o     ),
    .resp_req_o       (resp_req_o     ),
    .resp_o           (resp_o         ),
    .resp_ack_i       (resp_ack_i     ),
    .insn_push_valid_o(insn_push_valid),
    .insn_push_data_o (insn_push_data ),
    .insn_push_ready_i(insn_push_ready),
    .res_pop_valid_i  (res_pop_valid  ),
    .res_pop_data_i   (res_pop_data   ),
    .res_pop_ready_o  (res_pop_ready  )
  );

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  insn_fifo #(
    .payload_t(vinsn_t      ),
    .Depth    (InsnFifoDepth)
  ) i_insn_fifo (
    .clk_i       (clk_i          ),
    .rst_n_i     (rst_n_i        ),
    .push_valid_i(insn_push_valid),
    .push_data_i (insn_push_data ),
    .push_ready_o(insn_push_ready),
    .pop_valid_o (insn_pop_valid ),
    .pop_ready_i (insn_pop_ready ),
    .pop_data_o  (insn_pop_data  )
  );

  insn_fifo #(
    .payload_t(vres_t      ),
    .Depth    (ResFifoDepth)
  ) i_res_fifo (
    .clk_i       (clk_i         ),
    .rst_n_i     (rst_n_i       ),
    .push_valid_i(res_push_valid),
    .push_data_i (res_push_data ),
    .push_ready_o(res_push_ready),
    .pop_valid_o (res_pop_valid ),
    .pop_ready_i (res_pop_ready ),
    .pop_data_o  (res_pop_data  )
  );

  //////////////////////////////////////////////////
  // Sequencer and lanes
  //////////////////////////////////////////////////

  vec_sequencer i_sequencer (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .insn_pop_valid_i(insn_pop_valid),
    .insn_pop_data_i (insn_pop_data ),
    .insn_pop_ready_o(insn_pop_ready),
    .lane_cmd_o      (lane_cmd      ),
    .lane_issue_o    (lane_issue    ),
    .lane_elem_i     (lane_elem     ),
    .res_push_valid_o(res_push_valid),
    .res_push_data_o (res_push_data ),
    .res_push_ready_i(res_push_ready)
  );

  for (genvar gi = 0; gi < NrLanes; gi++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i    (clk_i          ),
      .rst_n_i  (rst_n_i        ),
      .lane_id_i(lane_idx_t'(gi)),
      .cmd_i    (lane_cmd       ),
      .issue_i  (lane_issue     ),
      .elem_o   (lane_elem[gi]  )
    );
  end : gen_lanes

endmodule : ara_top

//--- insn_fifo.sv
//////////////////////////////////////////////////
// Circular buffer FIFO
// Valid/ready push and pop, payload set by a type
// parameter, head entry shown combinationally
//////////////////////////////////////////////////

`timescale 1ns/10ps

module insn_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Push side
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  // Pop side
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  typedef logic [$clog2(Depth)-1:0]   ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] cnt_t;

  payload_t mem_q [Depth];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  cnt_t     count_q;
  logic     push;
  logic     pop;

  // Pointer advance with wrap at Depth
  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign push_ready_o = (count_q != cnt_t'(Depth));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Occupancy only moves when exactly one side fires
      case ({push, pop})
        2'b10:   count_q <= count_q + cnt_t'(1);
        2'b01:   count_q <= count_q - cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= cnt_t'(Depth))
    else $error("FIFO occupancy above its depth");

endmodule : insn_fifo

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and scan the log for a failure

cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_ara -f sources.f -o sim_ara \
  && ./obj_dir/sim_ara > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "SIMULATION FAILED" sim.log \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail, see sim.log"; exit 1; }

//--- sources.f
ara_cfg_pkg.sv
ara_insn_pkg.sv
insn_fifo.sv
vec_dispatcher.sv
vec_sequencer.sv
vec_lane.sv
ara_top.sv
tb_checker.sv
tb_ara.sv

//--- tb_ara.sv
//////////////////////////////////////////////////
// Testbench for the vector accelerator
// Clock and reset, stimulus table, four-phase
// core driver, response acknowledger and LCG
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_ara import ara_cfg_pkg::*, ara_insn_pkg::*; ();

  localparam logic [31:0] SEED          = 32'h830f;
  localparam int          TIMEOUT       = 200;
  localparam int          DRAIN_TIMEOUT = 2000;
  localparam int          SLOW_ACK      = 24;

  logic        clk;
  logic        rst_n;
  logic        insn_req;
  vinsn_t      insn;
  logic        resp_ack = 1'b0;
  logic        insn_ack;
  logic        resp_req;
  vres_t       resp;
  logic        slow_ack = 1'b0;
  logic [31:0] rng_drv  = SEED;
  logic [31:0] rng_ack  = SEED;
  int          ack_delay = 0;
  int          timeouts  = 0;
  int          mismatch_cnt;
  int          protocol_cnt;
  int          resp_cnt;

  // Stimulus table, one entry per instruction
  string  step_name[$];
  vinsn_t step_insn[$];
  logic   step_check[$];
  elen_t  step_exp[$];
  logic   step_slow[$];

  ara_top i_dut (
    .clk_i     (clk     ),
    .rst_n_i   (rst_n   ),
    .insn_req_i(insn_req),
    .insn_i    (insn    ),
    .insn_ack_o(insn_ack),
    .resp_req_o(resp_req),
    .resp_o    (resp    ),
    .resp_ack_i(resp_ack)
  );

  tb_checker i_checker (
    .clk_i         (clk         ),
    .rst_n_i       (rst_n       ),
    .insn_req_i    (insn_req    ),
    .insn_ack_i    (insn_ack    ),
    .resp_req_i    (resp_req    ),
    .resp_i        (resp        ),
    .resp_ack_i    (resp_ack    ),
    .mismatch_cnt_o(mismatch_cnt),
    .protocol_cnt_o(protocol_cnt),
    .resp_cnt_o    (resp_cnt    )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_step(input string name, input vop_e op, input vreg_idx_t vd,
                          input vreg_idx_t vs1, input vreg_idx_t vs2, input elen_t scalar,
                          input logic check, input elen_t exp, input logic slow);
    vinsn_t entry;
    entry.op     = op;
    entry.vd     = vd;
    entry.vs1    = vs1;
    entry.vs2    = vs2;
    entry.scalar = scalar;
    step_name.push_back(name);
    step_insn.push_back(entry);
    step_check.push_back(check);
    step_exp.push_back(exp);
    step_slow.push_back(slow);
  endtask

  ////////////////////////////////////////////////
  // Expected sums from the lane rules
  ////////////////////////////////////////////////

  task automatic build_table();
    elen_t sc;
    add_step("reset_redsum", VREDSUM_VS, 3'd0, 3'd0, 3'd4, 32'd7, 1'b1, 32'd7, 1'b0);
    add_step("splat_v1", VMV_VX, 3'd1, 3'd0, 3'd0, 32'd5, 1'b0, 32'd0, 1'b0);
    add_step("splat_redsum", VREDSUM_VS, 3'd0, 3'd0, 3'd1, 32'd3, 1'b1, 32'd23, 1'b0);
    add_step("vid_v2", VID_V, 3'd2, 3'd0, 3'd0, 32'd0, 1'b0, 32'd0, 1'b0);
    add_step("vaddvx_v2", VADD_VX, 3'd2, 3'd0, 3'd2, 32'd10, 1'b0, 32'd0, 1'b0);
    add_step("vaddvv_v3", VADD_VV, 3'd3, 3'd1, 3'd2, 32'd0, 1'b0, 32'd0, 1'b0);
    // v3 holds 15..18, so 100 + 66
    add_step("add_redsum", VREDSUM_VS, 3'd0, 3'd0, 3'd3, 32'd100, 1'b1, 32'd166, 1'b0);
    add_step("vxor_v2", VXOR_VX, 3'd2, 3'd0, 3'd2, 32'hffffffff, 1'b0, 32'd0, 1'b0);
    // Elements -11..-14 sum to -50, plus 64 wraps to 14
    add_step("xor_redsum", VREDSUM_VS, 3'd0, 3'd0, 3'd2, 32'h40, 1'b1, 32'h0000000e, 1'b0);
    for (int k = 0; k < 8; k++) begin
      sc = 32'h1000 * (k + 1);
      add_step($sformatf("backpressure_%0d", k), VREDSUM_VS, 3'd0, 3'd0, 3'd3, sc,
               1'b1, sc + 32'd66, 1'b1);
    end
  endtask

  // Four-phase request on the instruction channel
  task automatic send_insn(input vinsn_t next, input string name);
    int cnt;
    cnt      = 0;
    insn     = next;
    insn_req = 1'b1;
    @(negedge clk);
    while (!insn_ack && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!insn_ack) begin
      timeouts++;
      $display("error: %s timed out waiting for insn_ack_o to rise", name);
    end
    insn_req = 1'b0;
    cnt      = 0;
    @(negedge clk);
    while (insn_ack && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (insn_ack) begin
      timeouts++;
      $display("error: %s timed out waiting for insn_ack_o to fall", name);
    end
  endtask

  // Core side of the response channel, random ack latency
  always @(negedge clk) begin : ack_responder
    if (resp_req && !resp_ack) begin
      if (ack_delay == 0) begin
        resp_ack = 1'b1;
      end else begin
        ack_delay--;
      end
    end else if (!resp_req && resp_ack) begin
      resp_ack  = 1'b0;
      rng_ack   = lcg_next(rng_ack);
      ack_delay = int'(rng_ack[18:16]) + (slow_ack ? SLOW_ACK : 0);
    end
  end

  initial begin
    int cnt;
    int expected_cnt;
    cnt          = 0;
    expected_cnt = 0;
    rst_n        = 1'b0;
    insn_req     = 1'b0;
    insn         = '0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < step_name.size(); i++) begin
      slow_ack = step_slow[i];
      if (step_check[i]) begin
        i_checker.add_expected(step_name[i], step_exp[i]);
        expected_cnt++;
      end
      send_insn(step_insn[i], step_name[i]);
      rng_drv = lcg_next(rng_drv);
      repeat (rng_drv[18:16]) @(negedge clk);
    end

    // Drain the outstanding responses
    while (resp_cnt < expected_cnt && cnt < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (resp_cnt < expected_cnt) begin
      timeouts++;
      $display("error: only %0d of %0d responses arrived", resp_cnt, expected_cnt);
    end

    $display("errors mismatch=%0d protocol=%0d timeout=%0d",
             mismatch_cnt, protocol_cnt, timeouts);
    if (mismatch_cnt + protocol_cnt + timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_ara

//--- tb_checker.sv
//////////////////////////////////////////////////
// Response checker for the vector accelerator
// Queue of expected reduction results, comparison
// of every response and handshake protocol checks
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_checker import ara_cfg_pkg::*, ara_insn_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Instruction channel
  input  logic  insn_req_i,
  input  logic  insn_ack_i,
  // Response channel
  input  logic  resp_req_i,
  input  vres_t resp_i,
  input  logic  resp_ack_i,
  // Counters for the testbench top
  output int    mismatch_cnt_o,
  output int    protocol_cnt_o,
  output int    resp_cnt_o
);

  string names_q[$];
  elen_t values_q[$];
  int    mismatches = 0;
  int    violations = 0;
  int    responses  = 0;
  logic  resp_req_q = 1'b0;
  logic  resp_ack_q = 1'b0;
  logic  insn_ack_q = 1'b0;
  logic  insn_req_q = 1'b0;
  vres_t resp_q;

  assign mismatch_cnt_o = mismatches;
  assign protocol_cnt_o = violations;
  assign resp_cnt_o     = responses;

  // Queued in instruction order, responses come back in the same order
  task automatic add_expected(input string name, input elen_t value);
    names_q.push_back(name);
    values_q.push_back(value);
  endtask

  always @(posedge clk_i) begin : check_ports
    string name;
    elen_t expected;
    if (!rst_n_i) begin
      if (insn_ack_i || resp_req_i) begin
        violations++;
        $display("error: handshake output is high during reset");
      end
    end else begin
      // Ack rose on the previous edge, req must have been high there
      if (insn_ack_i && !insn_ack_q && !insn_req_q) begin
        violations++;
        $display("error: insn_ack_o rose while insn_req_i was low");
      end
      if (resp_req_i && resp_req_q && (resp_i != resp_q)) begin
        violations++;
        $display("error: resp_o changed while resp_req_o was high");
      end
      // Take one result per request phase
      if (resp_req_i && !resp_req_q) begin
        if (resp_ack_q) begin
          violations++;
          $display("error: resp_req_o rose before resp_ack_i was released");
        end
        if (values_q.size() == 0) begin
          violations++;
          $display("error: a response arrived while no result was expected");
        end else begin
          name     = names_q.pop_front();
          expected = values_q.pop_front();
          responses++;
          if (resp_i.result !== expected) begin
            mismatches++;
            $display("mismatch test=%s expected=%h actual=%h", name, expected, resp_i.result);
          end
        end
      end
    end
    resp_req_q = resp_req_i;
    resp_ack_q = resp_ack_i;
    insn_ack_q = insn_ack_i;
    insn_req_q = insn_req_i;
    resp_q     = resp_i;
  end

endmodule : tb_checker

//--- vec_dispatcher.sv
//////////////////////////////////////////////////
// Core-side dispatcher
// Four-phase instruction channel into the insn FIFO
// Four-phase response channel out of the result FIFO
//////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_dispatcher import ara_insn_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  // Core instruction channel
  input  logic   insn_req_i,
  input  vinsn_t insn_i,
  output logic   insn_ack_o,
  // Core response channel
  output logic   resp_req_o,
  output vres_t  resp_o,
  input  logic   resp_ack_i,
  // Instruction FIFO push side
  output logic   insn_push_valid_o,
  output vinsn_t insn_push_data_o,
  input  logic   insn_push_ready_i,
  // Result FIFO pop side
  input  logic   res_pop_valid_i,
  input  vres_t  res_pop_data_i,
  output logic   res_pop_ready_o
);

  typedef enum logic {INSN_IDLE, INSN_ACK} insn_state_e;
  typedef enum logic [1:0] {RESP_IDLE, RESP_SETUP, RESP_REQ, RESP_DROP} resp_state_e;

  insn_state_e insn_state_q, insn_state_d;
  resp_state_e resp_state_q, resp_state_d;
  vres_t       resp_q;

  //////////////////////////////////////////////////
  // Instruction handshake
  //////////////////////////////////////////////////

  // One push per request, then hold ack until req drops
  assign insn_push_valid_o = (insn_state_q == INSN_IDLE) && insn_req_i;
  assign insn_push_data_o  = insn_i;
  assign insn_ack_o        = (insn_state_q == INSN_ACK);

  always_comb begin
    insn_state_d = insn_state_q;
    case (insn_state_q)
      INSN_IDLE: begin
        if (insn_req_i && insn_push_ready_i) begin
          insn_state_d = INSN_ACK;
        end
      end
      INSN_ACK: begin
        if (!insn_req_i) begin
          insn_state_d = INSN_IDLE;
        end
      end
      default: insn_state_d = INSN_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Response handshake
  //////////////////////////////////////////////////

  // Data sits on resp_o for a setup cycle before req rises
  assign res_pop_ready_o = (resp_state_q == RESP_IDLE);
  assign resp_req_o      = (resp_state_q == RESP_REQ);
  assign resp_o          = resp_q;

  always_comb begin
    resp_state_d = resp_state_q;
    case (resp_state_q)
      RESP_IDLE: begin
        if (res_pop_valid_i) begin
          resp_state_d = RESP_SETUP;
        end
      end
      RESP_SETUP: resp_state_d = RESP_REQ;
      RESP_REQ: begin
        if (resp_ack_i) begin
          resp_state_d = RESP_DROP;
        end
      end
      // Wait for the core to release ack before the next pop
      RESP_DROP: begin
        if (!resp_ack_i) begin
          resp_state_d = RESP_IDLE;
        end
      end
      default: resp_state_d = RESP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      insn_state_q <= INSN_IDLE;
      resp_state_q <= RESP_IDLE;
    end else begin
      insn_state_q <= insn_state_d;
      resp_state_q <= resp_state_d;
    end
  end

  // Holding register for the popped result
  always_ff @(posedge clk_i) begin
    if (res_pop_valid_i && res_pop_ready_o) begin
      resp_q <= res_pop_data_i;
    end
  end

  // Ack may only answer a pending request
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(insn_ack_o) |-> $past(insn_req_i))
    else $error("insn_ack_o rose while insn_req_i was low");

  // Response payload held for the whole request phase
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_req_o |-> $stable(resp_o))
    else $error("resp_o changed while resp_req_o was high");

endmodule : vec_dispatcher

//--- vec_lane.sv
//////////////////////////////////////////////////
// Vector lane
// One element of every vector register and the
// element ALU that writes it
//////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_lane import ara_cfg_pkg::*, ara_insn_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  lane_idx_t lane_id_i,
  // Broadcast from the sequencer
  input  vinsn_t    cmd_i,
  input  logic      issue_i,
  // vs2 element for reductions
  output elen_t     elem_o
);

  elen_t [NrVRegs-1:0] vrf_q;
  elen_t               vs1_elem;
  elen_t               vs2_elem;
  elen_t               alu_result;

  // Register file reads
  assign vs1_elem = vrf_q[cmd_i.vs1];
  assign vs2_elem = vrf_q[cmd_i.vs2];
  assign elem_o   = vs2_elem;

  //////////////////////////////////////////////////
  // Element ALU
  //////////////////////////////////////////////////

  always_comb begin
    case (cmd_i.op)
      VMV_VX:  alu_result = cmd_i.scalar;
      // One element per lane, so the element index is the lane id
      VID_V:   alu_result = elen_t'(lane_id_i);
      VADD_VX: alu_result = vs2_elem + cmd_i.scalar;
      VADD_VV: alu_result = vs1_elem + vs2_elem;
      VXOR_VX: alu_result = vs2_elem ^ cmd_i.scalar;
      default: alu_result = vs2_elem;
    endcase
  end

  //////////////////////////////////////////////////
  // Register file write
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vrf_q <= '0;
    end else if (issue_i && !is_reduction(cmd_i.op)) begin
      vrf_q[cmd_i.vd] <= alu_result;
    end
  end

endmodule : vec_lane

//--- vec_sequencer.sv
//////////////////////////////////////////////////
// Vector sequencer
// Issues the head instruction to all lanes and
// forms the sum of a reduction for the result FIFO
//////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_sequencer import ara_cfg_pkg::*, ara_insn_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Instruction FIFO pop side
  input  logic                insn_pop_valid_i,
  input  vinsn_t              insn_pop_data_i,
  output logic                insn_pop_ready_o,
  // Lane array
  output vinsn_t              lane_cmd_o,
  output logic                lane_issue_o,
  input  elen_t [NrLanes-1:0] lane_elem_i,
  // Result FIFO push side
  output logic                res_push_valid_o,
  output vres_t               res_push_data_o,
  input  logic                res_push_ready_i
);

  logic  head_is_red;
  elen_t red_sum;

  //////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////

  assign head_is_red = is_reduction(insn_pop_data_i.op);

  // Element ops always go, a reduction waits for room in the result FIFO
  assign insn_pop_ready_o = !head_is_red || res_push_ready_i;

  // Every op finishes in one cycle and in order,
  // so a pop is an issue
  assign lane_issue_o = insn_pop_valid_i && insn_pop_ready_o;
  assign lane_cmd_o   = insn_pop_data_i;

  //////////////////////////////////////////////////
  // Reduction
  //////////////////////////////////////////////////

  // Scalar plus the vs2 element of every lane, wraps modulo 2^32
  always_comb begin
    red_sum = insn_pop_data_i.scalar;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      red_sum = red_sum + lane_elem_i[l];
    end
  end

  // Push and pop fire on the same edge
  assign res_push_valid_o = insn_pop_valid_i && head_is_red;
  assign res_push_data_o  = '{result: red_sum};

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_issue_o |-> insn_pop_valid_i)
    else $error("Lane issue without a valid instruction at the FIFO head");

endmodule : vec_sequencer
